// File: lpif_flit_pkg.sv
// Flit and lane layout for the two-lane LPIF link
// Flit field widths
// Lane split and PHY word framing positions
// Packed flit union with field and lane views
package lpif_flit_pkg;

  // Flit fields
  localparam int state_width  = 4;
  localparam int protid_width = 2;
  localparam int data_width   = 128;
  localparam int crc_width    = 16;
  localparam int flit_width   = 153;

  // Lane split, lane0 carries the low flit bits
  localparam int lane0_bits = 77;
  localparam int lane1_bits = flit_width - lane0_bits;

  // PHY word, payload at the bottom, framing on top
  localparam int phy_width    = 80;
  localparam int strobe_bit   = lane0_bits;
  localparam int marker_lsb   = strobe_bit + 1;
  localparam int marker_width = 2;

  typedef struct packed {
    logic [state_width-1:0]  state;
    logic [protid_width-1:0] protid;
    logic [data_width-1:0]   data;
    logic                    dvalid;
    logic [crc_width-1:0]    crc;
    logic                    crc_valid;
    logic                    valid;
  } lpif_flit_fields_t;

  typedef struct packed {
    logic [lane1_bits-1:0] lane1;
    logic [lane0_bits-1:0] lane0;
  } lpif_flit_lanes_t;

  // Same 153 bits seen by the user side and by the PHY side
  typedef union packed {
    lpif_flit_fields_t fields;
    lpif_flit_lanes_t  lanes;
  } lpif_flit_u;

endpackage

// File: lpif_cfg_pkg.sv
// Configuration space of the LPIF link
// AXI4-Lite widths and register offsets
// Delay reset values and response codes
package lpif_cfg_pkg;

  localparam int axi_addr_width = 8;
  localparam int axi_data_width = 32;
  localparam int delay_width    = 16;
  localparam int count_width    = 32;

  // Register map
  localparam logic [axi_addr_width-1:0] addr_delay_x   = 8'h00;
  localparam logic [axi_addr_width-1:0] addr_delay_y   = 8'h04;
  localparam logic [axi_addr_width-1:0] addr_delay_z   = 8'h08;
  localparam logic [axi_addr_width-1:0] addr_tx_status = 8'h0C;
  localparam logic [axi_addr_width-1:0] addr_rx_status = 8'h10;

  // Delays after reset
  localparam logic [delay_width-1:0] delay_x_reset = 16'd8;
  localparam logic [delay_width-1:0] delay_y_reset = 16'd4;
  localparam logic [delay_width-1:0] delay_z_reset = 16'd16;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

endpackage

// File: lpif_cfg_regs.sv
// AXI4-Lite register slave of the LPIF link
// Delay x/y/z registers with byte strobes
// Read back of the tx and rx flit counters
// SLVERR on status writes and unmapped addresses
`timescale 1ns/1ps

module lpif_cfg_regs (
  input  logic                                      clk_wr,
  input  logic                                      reset,
  input  logic [lpif_cfg_pkg::axi_addr_width-1:0]   s_axi_awaddr,
  input  logic                                      s_axi_awvalid,
  output logic                                      s_axi_awready,
  input  logic [lpif_cfg_pkg::axi_data_width-1:0]   s_axi_wdata,
  input  logic [lpif_cfg_pkg::axi_data_width/8-1:0] s_axi_wstrb,
  input  logic                                      s_axi_wvalid,
  output logic                                      s_axi_wready,
  output logic [1:0]                                s_axi_bresp,
  output logic                                      s_axi_bvalid,
  input  logic                                      s_axi_bready,
  input  logic [lpif_cfg_pkg::axi_addr_width-1:0]   s_axi_araddr,
  input  logic                                      s_axi_arvalid,
  output logic                                      s_axi_arready,
  output logic [lpif_cfg_pkg::axi_data_width-1:0]   s_axi_rdata,
  output logic [1:0]                                s_axi_rresp,
  output logic                                      s_axi_rvalid,
  input  logic                                      s_axi_rready,
  input  logic [lpif_cfg_pkg::count_width-1:0]      tx_count,
  input  logic [lpif_cfg_pkg::count_width-1:0]      rx_count,
  output logic [lpif_cfg_pkg::delay_width-1:0]      delay_x,
  output logic [lpif_cfg_pkg::delay_width-1:0]      delay_y,
  output logic [lpif_cfg_pkg::delay_width-1:0]      delay_z
);

  import lpif_cfg_pkg::*;

  logic wr_fire;
  logic rd_fire;

  // Byte lanes of a delay register updated where wstrb is set
  function automatic logic [delay_width-1:0] merge_bytes(
    input logic [delay_width-1:0]      old_val,
    input logic [axi_data_width-1:0]   wdata,
    input logic [axi_data_width/8-1:0] wstrb
  );
    logic [delay_width-1:0] res;
    res = old_val;
    for (int b = 0; b < delay_width / 8; b++) begin
      if (wstrb[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Write channel

  // Address and data accepted together, one response outstanding
  assign wr_fire       = s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;
  assign s_axi_awready = wr_fire;
  assign s_axi_wready  = wr_fire;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      delay_x      <= delay_x_reset;
      delay_y      <= delay_y_reset;
      delay_z      <= delay_z_reset;
      s_axi_bvalid <= 1'b0;
      s_axi_bresp  <= resp_okay;
    end else if (wr_fire) begin
      s_axi_bvalid <= 1'b1;
      s_axi_bresp  <= resp_okay;
      case (s_axi_awaddr)
        addr_delay_x: delay_x <= merge_bytes(delay_x, s_axi_wdata, s_axi_wstrb);
        addr_delay_y: delay_y <= merge_bytes(delay_y, s_axi_wdata, s_axi_wstrb);
        addr_delay_z: delay_z <= merge_bytes(delay_z, s_axi_wdata, s_axi_wstrb);
        // Status is read only, rest unmapped
        default:      s_axi_bresp <= resp_slverr;
      endcase
    end else if (s_axi_bready) begin
      s_axi_bvalid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read channel

  // New address only while no read data is pending
  assign rd_fire       = s_axi_arvalid & ~s_axi_rvalid;
  assign s_axi_arready = rd_fire;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      s_axi_rvalid <= 1'b0;
    end else if (rd_fire) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // Data and response captured with the address
  always_ff @(posedge clk_wr) begin
    if (rd_fire) begin
      s_axi_rresp <= resp_okay;
      case (s_axi_araddr)
        addr_delay_x:   s_axi_rdata <= axi_data_width'(delay_x);
        addr_delay_y:   s_axi_rdata <= axi_data_width'(delay_y);
        addr_delay_z:   s_axi_rdata <= axi_data_width'(delay_z);
        addr_tx_status: s_axi_rdata <= tx_count;
        addr_rx_status: s_axi_rdata <= rx_count;
        default: begin
          s_axi_rdata <= '0;
          s_axi_rresp <= resp_slverr;
        end
      endcase
    end
  end

endmodule

// File: lpif_auto_sync.sv
// Link qualification and framing for the LPIF link
// Online delay counters for tx (delay_y) and rx (delay_x)
// Strobe every delay_z words and a free running 2-bit marker
`timescale 1ns/1ps

module lpif_auto_sync (
  input  logic                                   clk_wr,
  input  logic                                   reset,
  input  logic                                   tx_online,
  input  logic                                   rx_online,
  input  logic [lpif_cfg_pkg::delay_width-1:0]   delay_x,
  input  logic [lpif_cfg_pkg::delay_width-1:0]   delay_y,
  input  logic [lpif_cfg_pkg::delay_width-1:0]   delay_z,
  output logic                                   tx_online_delay,
  output logic                                   rx_online_delay,
  output logic                                   tx_strobe,
  output logic [lpif_flit_pkg::marker_width-1:0] tx_marker
);

  import lpif_cfg_pkg::*;
  import lpif_flit_pkg::*;

  logic [1:0]              online;
  logic [1:0]              online_q;
  logic [delay_width-1:0]  online_delay [2];
  logic [delay_width-1:0]  word_cnt;
  logic [marker_width-1:0] marker;

  ////////////////////////////////////////////////////////////
  // Online qualification

  // Index 0 is the tx side, index 1 the rx side
  assign online          = {rx_online, tx_online};
  assign online_delay[0] = delay_y;
  assign online_delay[1] = delay_x;

  for (genvar i = 0; i < 2; i++) begin : g_online
    logic [delay_width-1:0] cnt;
    logic                   q;

    // Saturates once the delay is reached, any low input restarts
    always_ff @(posedge clk_wr) begin
      if (reset || !online[i]) begin
        cnt <= '0;
        q   <= 1'b0;
      end else if ({1'b0, cnt} + 1'b1 >= {1'b0, online_delay[i]}) begin
        q <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end

    assign online_q[i] = q;
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  ////////////////////////////////////////////////////////////
  // Strobe and marker

  // Word index modulo delay_z; 0 or 1 strobes every word
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      word_cnt <= '0;
      marker   <= '0;
    end else begin
      marker <= marker + 1'b1;
      if ({1'b0, word_cnt} + 1'b1 >= {1'b0, delay_z}) begin
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // Framing bits only while tx_online is up
  assign tx_strobe = tx_online & (word_cnt == '0);
  assign tx_marker = tx_online ? marker : '0;

endmodule

// File: lpif_flit_pack.sv
// User side of the LPIF link
// Downstream flit register into the field view
// Upstream field decode, valids held off until rx is online
// Transmit and receive flit counters
`timescale 1ns/1ps

module lpif_flit_pack (
  input  logic                                   clk_wr,
  input  logic                                   reset,
  input  logic [lpif_flit_pkg::state_width-1:0]  dstrm_state,
  input  logic [lpif_flit_pkg::protid_width-1:0] dstrm_protid,
  input  logic [lpif_flit_pkg::data_width-1:0]   dstrm_data,
  input  logic                                   dstrm_dvalid,
  input  logic [lpif_flit_pkg::crc_width-1:0]    dstrm_crc,
  input  logic                                   dstrm_crc_valid,
  input  logic                                   dstrm_valid,
  output logic [lpif_flit_pkg::state_width-1:0]  ustrm_state,
  output logic [lpif_flit_pkg::protid_width-1:0] ustrm_protid,
  output logic [lpif_flit_pkg::data_width-1:0]   ustrm_data,
  output logic                                   ustrm_dvalid,
  output logic [lpif_flit_pkg::crc_width-1:0]    ustrm_crc,
  output logic                                   ustrm_crc_valid,
  output logic                                   ustrm_valid,
  output lpif_flit_pkg::lpif_flit_u              tx_flit,
  input  lpif_flit_pkg::lpif_flit_u              rx_flit,
  input  logic                                   rx_online_delay,
  output logic [lpif_cfg_pkg::count_width-1:0]   tx_count,
  output logic [lpif_cfg_pkg::count_width-1:0]   rx_count
);

  ////////////////////////////////////////////////////////////
  // Downstream

  // One register stage, CRC carried through untouched
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_flit <= '0;
    end else begin
      tx_flit.fields.state     <= dstrm_state;
      tx_flit.fields.protid    <= dstrm_protid;
      tx_flit.fields.data      <= dstrm_data;
      tx_flit.fields.dvalid    <= dstrm_dvalid;
      tx_flit.fields.crc       <= dstrm_crc;
      tx_flit.fields.crc_valid <= dstrm_crc_valid;
      tx_flit.fields.valid     <= dstrm_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // Upstream

  assign ustrm_state     = rx_flit.fields.state;
  assign ustrm_protid    = rx_flit.fields.protid;
  assign ustrm_data      = rx_flit.fields.data;
  assign ustrm_crc       = rx_flit.fields.crc;
  // Qualifiers dropped until the rx delay has expired
  assign ustrm_dvalid    = rx_flit.fields.dvalid & rx_online_delay;
  assign ustrm_crc_valid = rx_flit.fields.crc_valid & rx_online_delay;
  assign ustrm_valid     = rx_flit.fields.valid & rx_online_delay;

  // Debug counters, wrap at 32 bits
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_count <= '0;
      rx_count <= '0;
    end else begin
      if (tx_flit.fields.valid) begin
        tx_count <= tx_count + 1'b1;
      end
      if (ustrm_valid) begin
        rx_count <= rx_count + 1'b1;
      end
    end
  end

endmodule

// File: lpif_phy_concat.sv
// PHY side of the LPIF link
// Flit split onto two 80-bit lanes with strobe and marker
// Payload zeroed until tx is online
// Receive lanes registered and reassembled into the flit
`timescale 1ns/1ps

module lpif_phy_concat (
  input  logic                                   clk_wr,
  input  logic                                   reset,
  input  lpif_flit_pkg::lpif_flit_u              tx_flit,
  input  logic                                   tx_online_delay,
  input  logic                                   tx_strobe,
  input  logic [lpif_flit_pkg::marker_width-1:0] tx_marker,
  output logic [lpif_flit_pkg::phy_width-1:0]    tx_phy0,
  output logic [lpif_flit_pkg::phy_width-1:0]    tx_phy1,
  input  logic [lpif_flit_pkg::phy_width-1:0]    rx_phy0,
  input  logic [lpif_flit_pkg::phy_width-1:0]    rx_phy1,
  output lpif_flit_pkg::lpif_flit_u              rx_flit
);

  import lpif_flit_pkg::*;

  logic [lane0_bits-1:0] tx_lane0;
  logic [lane1_bits-1:0] tx_lane1;

  // Lane word, payload low, strobe at 77, marker at 79:78
  function automatic logic [phy_width-1:0] frame_word(
    input logic [lane0_bits-1:0]   payload,
    input logic                    strobe,
    input logic [marker_width-1:0] marker
  );
    logic [phy_width-1:0] word;
    word                             = phy_width'(payload);
    word[strobe_bit]                 = strobe;
    word[marker_lsb +: marker_width] = marker;
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // Transmit

  // Payload held at zero while the tx delay runs
  assign tx_lane0 = tx_online_delay ? tx_flit.lanes.lane0 : '0;
  assign tx_lane1 = tx_online_delay ? tx_flit.lanes.lane1 : '0;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= frame_word(tx_lane0, tx_strobe, tx_marker);
      // Lane1 is one bit short, bit 76 stays zero
      tx_phy1 <= frame_word(lane0_bits'(tx_lane1), tx_strobe, tx_marker);
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive

  // Framing bits stripped on capture
  always_ff @(posedge clk_wr) begin
    rx_flit.lanes.lane0 <= rx_phy0[lane0_bits-1:0];
    rx_flit.lanes.lane1 <= rx_phy1[lane1_bits-1:0];
  end

endmodule

// File: lpif_link_top.sv
// Top level of the two-lane LPIF link layer
// AXI4-Lite register block, flit packer, auto-sync, PHY concatenator
// Debug status ports carry the flit counters
`timescale 1ns/1ps

module lpif_link_top (
  input  logic                                      clk_wr,
  input  logic                                      reset,
  // AXI4-Lite configuration
  input  logic [lpif_cfg_pkg::axi_addr_width-1:0]   s_axi_awaddr,
  input  logic                                      s_axi_awvalid,
  output logic                                      s_axi_awready,
  input  logic [lpif_cfg_pkg::axi_data_width-1:0]   s_axi_wdata,
  input  logic [lpif_cfg_pkg::axi_data_width/8-1:0] s_axi_wstrb,
  input  logic                                      s_axi_wvalid,
  output logic                                      s_axi_wready,
  output logic [1:0]                                s_axi_bresp,
  output logic                                      s_axi_bvalid,
  input  logic                                      s_axi_bready,
  input  logic [lpif_cfg_pkg::axi_addr_width-1:0]   s_axi_araddr,
  input  logic                                      s_axi_arvalid,
  output logic                                      s_axi_arready,
  output logic [lpif_cfg_pkg::axi_data_width-1:0]   s_axi_rdata,
  output logic [1:0]                                s_axi_rresp,
  output logic                                      s_axi_rvalid,
  input  logic                                      s_axi_rready,
  // Link control
  input  logic                                      tx_online,
  input  logic                                      rx_online,
  // PHY lanes
  output logic [lpif_flit_pkg::phy_width-1:0]       tx_phy0,
  output logic [lpif_flit_pkg::phy_width-1:0]       tx_phy1,
  input  logic [lpif_flit_pkg::phy_width-1:0]       rx_phy0,
  input  logic [lpif_flit_pkg::phy_width-1:0]       rx_phy1,
  // Downstream flit
  input  logic [lpif_flit_pkg::state_width-1:0]     dstrm_state,
  input  logic [lpif_flit_pkg::protid_width-1:0]    dstrm_protid,
  input  logic [lpif_flit_pkg::data_width-1:0]      dstrm_data,
  input  logic                                      dstrm_dvalid,
  input  logic [lpif_flit_pkg::crc_width-1:0]       dstrm_crc,
  input  logic                                      dstrm_crc_valid,
  input  logic                                      dstrm_valid,
  // Upstream flit
  output logic [lpif_flit_pkg::state_width-1:0]     ustrm_state,
  output logic [lpif_flit_pkg::protid_width-1:0]    ustrm_protid,
  output logic [lpif_flit_pkg::data_width-1:0]      ustrm_data,
  output logic                                      ustrm_dvalid,
  output logic [lpif_flit_pkg::crc_width-1:0]       ustrm_crc,
  output logic                                      ustrm_crc_valid,
  output logic                                      ustrm_valid,
  // Debug status
  output logic [lpif_cfg_pkg::count_width-1:0]      tx_downstream_debug_status,
  output logic [lpif_cfg_pkg::count_width-1:0]      rx_upstream_debug_status
);

  import lpif_cfg_pkg::*;
  import lpif_flit_pkg::*;

  ////////////////////////////////////////////////////////////
  // Interconnect

  logic [delay_width-1:0]  delay_x;
  logic [delay_width-1:0]  delay_y;
  logic [delay_width-1:0]  delay_z;
  lpif_flit_u              tx_flit;
  lpif_flit_u              rx_flit;
  logic                    tx_online_delay;
  logic                    rx_online_delay;
  logic                    tx_strobe;
  logic [marker_width-1:0] tx_marker;
  logic [count_width-1:0]  tx_count;
  logic [count_width-1:0]  rx_count;

  // Counters shared by the status registers and the debug ports
  assign tx_downstream_debug_status = tx_count;
  assign rx_upstream_debug_status   = rx_count;

  ////////////////////////////////////////////////////////////
  // Blocks, all port names match the nets above

  lpif_cfg_regs u_cfg_regs (.*);

  lpif_auto_sync u_auto_sync (.*);

  lpif_flit_pack u_flit_pack (.*);

  // Single clock, no crossing between write and read sides
  lpif_phy_concat u_phy_concat (.*);

endmodule

// File: lpif_link_properties.sv
// Concurrent checks on the LPIF link top-level ports
// Idle outputs and zero counters after reset
// AXI4-Lite response hold and accept rules
`timescale 1ns/1ps

module lpif_link_properties (
  input logic                                    clk_wr,
  input logic                                    reset,
  input logic                                    s_axi_awready,
  input logic                                    s_axi_wready,
  input logic [1:0]                              s_axi_bresp,
  input logic                                    s_axi_bvalid,
  input logic                                    s_axi_bready,
  input logic                                    s_axi_arready,
  input logic [lpif_cfg_pkg::axi_data_width-1:0] s_axi_rdata,
  input logic [1:0]                              s_axi_rresp,
  input logic                                    s_axi_rvalid,
  input logic                                    s_axi_rready,
  input logic                                    ustrm_valid,
  input logic                                    ustrm_dvalid,
  input logic                                    ustrm_crc_valid,
  input logic [lpif_cfg_pkg::count_width-1:0]    tx_downstream_debug_status,
  input logic [lpif_cfg_pkg::count_width-1:0]    rx_upstream_debug_status
);

  import lpif_cfg_pkg::*;

  // Failures seen so far, read by the testbench report
  int fail_count = 0;

  // Master is idle in the cycle after reset
  reset_state: assert property (@(posedge clk_wr)
    reset |=> !s_axi_bvalid && !s_axi_rvalid && !s_axi_awready && !s_axi_wready &&
              !s_axi_arready && !ustrm_valid && !ustrm_dvalid && !ustrm_crc_valid &&
              tx_downstream_debug_status == '0 && rx_upstream_debug_status == '0)
  else begin
    fail_count++;
    $error("link outputs not idle after reset");
  end

  // Write response held until bready
  bresp_hold: assert property (@(posedge clk_wr) disable iff (reset)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
  else begin
    fail_count++;
    $error("bvalid or bresp dropped before bready");
  end

  // Read data held until rready
  rdata_hold: assert property (@(posedge clk_wr) disable iff (reset)
    s_axi_rvalid && !s_axi_rready |=>
      s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
  else begin
    fail_count++;
    $error("rvalid, rdata or rresp changed before rready");
  end

  // Address and data accepted together, never while a response waits
  write_accept: assert property (@(posedge clk_wr) disable iff (reset)
    (s_axi_awready == s_axi_wready) && !(s_axi_bvalid && s_axi_awready))
  else begin
    fail_count++;
    $error("write accept rule broken");
  end

  read_accept: assert property (@(posedge clk_wr) disable iff (reset)
    s_axi_rvalid |-> !s_axi_arready)
  else begin
    fail_count++;
    $error("read address accepted with read data pending");
  end

endmodule

// File: tb_lpif_link.sv
// Testbench for the two-lane LPIF link
// Clock, reset, AXI4-Lite write and read tasks
// Random flits over tx_phy looped back to rx_phy
// Cycle model of framing, gating and upstream flits
// Watchdog and closing report
`timescale 1ns/1ps

module tb_lpif_link;

  import lpif_flit_pkg::*;
  import lpif_cfg_pkg::*;

  localparam time clk_period     = 20ns;
  localparam time drive_delay    = 2ns;
  localparam int  reset_cycles   = 16;
  localparam int  axi_ops        = 16;
  localparam int  phase_a_cycles = 20;
  localparam int  phase_b_cycles = 40;
  localparam int  idle_cycles    = 8;
  localparam int  test_cycles    = reset_cycles + axi_ops * 5 + phase_a_cycles +
                                   phase_b_cycles + idle_cycles;

  logic                      clk_wr, reset, tx_online, rx_online;
  logic [axi_addr_width-1:0] s_axi_awaddr, s_axi_araddr;
  logic [axi_data_width-1:0] s_axi_wdata, s_axi_rdata;
  logic [3:0]                s_axi_wstrb;
  logic [1:0]                s_axi_bresp, s_axi_rresp;
  logic                      s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  logic                      s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic                      s_axi_rvalid, s_axi_rready;
  logic [phy_width-1:0]      tx_phy0, tx_phy1, rx_phy0, rx_phy1;
  logic [3:0]                dstrm_state, ustrm_state;
  logic [1:0]                dstrm_protid, ustrm_protid;
  logic [127:0]              dstrm_data, ustrm_data;
  logic [15:0]               dstrm_crc, ustrm_crc;
  logic                      dstrm_dvalid, dstrm_crc_valid, dstrm_valid;
  logic                      ustrm_dvalid, ustrm_crc_valid, ustrm_valid;
  logic [count_width-1:0]    tx_downstream_debug_status, rx_upstream_debug_status;

  // Model state
  logic [31:0]           rng;
  logic [flit_width-1:0] pipe [3];
  int tx_edges = 0;
  int rx_edges = 0;
  int tx_exp   = 0;
  int rx_exp   = 0;
  int errors   = 0;
  int delay_x_prog = delay_x_reset;
  int delay_y_prog = delay_y_reset;
  int delay_z_prog = delay_z_reset;

  lpif_link_top DUT (.*);

  bind lpif_link_top lpif_link_properties u_link_props (.*);

  // PHY loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  initial begin
    clk_wr = 1'b0;
    forever #(clk_period / 2) clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_equal(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Random fields, valid given by the caller
  task automatic drive_flit(input logic valid);
    logic [159:0] bits;
    for (int i = 0; i < 5; i++) begin
      rng = xorshift(rng);
      bits[i*32 +: 32] = rng;
    end
    dstrm_state     = bits[3:0];
    dstrm_protid    = bits[5:4];
    dstrm_data      = bits[133:6];
    dstrm_dvalid    = bits[134];
    dstrm_crc       = bits[150:135];
    dstrm_crc_valid = bits[151];
    dstrm_valid     = valid;
    @(posedge clk_wr);
    #drive_delay;
  endtask

  // Called and returns 2 ns after a rising edge
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] exp_resp);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    do @(negedge clk_wr); while (!s_axi_awready);
    @(posedge clk_wr);
    // Valids stay up through one cycle of response stall
    @(posedge clk_wr);
    #drive_delay;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    do @(negedge clk_wr); while (!s_axi_bvalid);
    check_equal("s_axi_bresp", s_axi_bresp, exp_resp);
    @(posedge clk_wr);
    #drive_delay;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do @(negedge clk_wr); while (!s_axi_arready);
    @(posedge clk_wr);
    // Address stays up through one cycle of read data stall
    @(posedge clk_wr);
    #drive_delay;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    do @(negedge clk_wr); while (!s_axi_rvalid);
    check_equal("s_axi_rdata", s_axi_rdata, exp_data);
    check_equal("s_axi_rresp", s_axi_rresp, exp_resp);
    @(posedge clk_wr);
    #drive_delay;
    s_axi_rready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model, two edges from dstrm sample to ustrm

  always @(posedge clk_wr) begin
    pipe[0]  <= {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                 dstrm_crc, dstrm_crc_valid, dstrm_valid};
    pipe[1]  <= pipe[0];
    pipe[2]  <= pipe[1];
    tx_edges <= tx_online ? tx_edges + 1 : 0;
    rx_edges <= rx_online ? rx_edges + 1 : 0;
    if (!reset && dstrm_valid) begin
      tx_exp <= tx_exp + 1;
    end
  end

  always @(negedge clk_wr) begin
    logic                  rx_ok;
    logic [flit_width-1:0] f;
    rx_ok = rx_edges >= delay_x_prog;
    f     = pipe[2];
    if (!reset) begin
      check_equal("ustrm_valid", ustrm_valid, f[0] & rx_ok);
      check_equal("ustrm_crc_valid", ustrm_crc_valid, f[1] & rx_ok);
      check_equal("ustrm_dvalid", ustrm_dvalid, f[18] & rx_ok);
      if (f[0] && rx_ok) begin
        rx_exp++;
        check_equal("ustrm_crc", ustrm_crc, f[17:2]);
        check_equal("ustrm_data", ustrm_data, f[146:19]);
        check_equal("ustrm_protid", ustrm_protid, f[148:147]);
        check_equal("ustrm_state", ustrm_state, f[152:149]);
      end
      // Marker 79:78 and strobe 77 on both lanes
      if (tx_edges > 0) begin
        check_equal("tx_phy0 marker", tx_phy0[79:78], (tx_edges - 1) % 4);
        check_equal("tx_phy1 marker", tx_phy1[79:78], (tx_edges - 1) % 4);
        check_equal("tx_phy0 strobe", tx_phy0[77], (tx_edges - 1) % delay_z_prog == 0);
        check_equal("tx_phy1 strobe", tx_phy1[77], (tx_edges - 1) % delay_z_prog == 0);
      end
      if (tx_edges > 0 && tx_edges <= delay_y_prog) begin
        check_equal("tx_phy0 payload", tx_phy0[76:0], '0);
        check_equal("tx_phy1 payload", tx_phy1[75:0], '0);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    reset = 1'b1;
    {tx_online, rx_online} = '0;
    {s_axi_awaddr, s_axi_awvalid, s_axi_wdata, s_axi_wstrb, s_axi_wvalid} = '0;
    {s_axi_bready, s_axi_araddr, s_axi_arvalid, s_axi_rready} = '0;
    {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid} = '0;
    {dstrm_crc, dstrm_crc_valid, dstrm_valid} = '0;
    rng = 32'd80;
    repeat (reset_cycles) @(posedge clk_wr);
    #drive_delay;
    reset = 1'b0;
    @(posedge clk_wr);
    #drive_delay;

    // Reset values and empty counters
    axi_read(8'h00, 32'd8, 2'd0);
    axi_read(8'h04, 32'd4, 2'd0);
    axi_read(8'h08, 32'd16, 2'd0);
    axi_read(8'h0C, 32'd0, 2'd0);
    axi_read(8'h10, 32'd0, 2'd0);
    check_equal("tx_downstream_debug_status", tx_downstream_debug_status, 0);
    check_equal("rx_upstream_debug_status", rx_upstream_debug_status, 0);

    // Low byte only, then writes that must be refused
    axi_write(8'h04, 32'h0000_3C02, 4'b0001, 2'd0);
    delay_y_prog = 2;
    axi_read(8'h04, 32'h0000_0002, 2'd0);
    axi_write(8'h0C, 32'h0000_0055, 4'b1111, 2'd2);
    axi_read(8'h0C, 32'd0, 2'd0);
    axi_write(8'h20, 32'h0000_0077, 4'b1111, 2'd2);
    axi_read(8'h20, 32'd0, 2'd2);
    // No aliasing of the unmapped write onto delay_x
    axi_read(8'h00, 32'd8, 2'd0);
    axi_write(8'h00, 32'h0000_0006, 4'b0011, 2'd0);
    delay_x_prog = 6;
    axi_write(8'h08, 32'h0000_0005, 4'b0011, 2'd0);
    delay_z_prog = 5;

    // Tx comes up alone, flits without valid
    tx_online = 1'b1;
    repeat (phase_a_cycles) drive_flit(1'b0);

    // Rx comes up under a stream of valid flits
    rx_online = 1'b1;
    repeat (phase_b_cycles) drive_flit(1'b1);
    repeat (idle_cycles) drive_flit(1'b0);

    axi_read(8'h0C, tx_exp, 2'd0);
    axi_read(8'h10, rx_exp, 2'd0);
    check_equal("tx_downstream_debug_status", tx_downstream_debug_status, tx_exp);
    check_equal("rx_upstream_debug_status", rx_upstream_debug_status, rx_exp);

    $display("Closing report: %0d check errors, %0d property failures",
             errors, DUT.u_link_props.fail_count);
    if (errors == 0 && DUT.u_link_props.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(test_cycles * clk_period + 1us);
    $display("Watchdog expired before the test sequence completed");
    $display("sim failed");
    $finish;
  end

endmodule

// File: src.f
lpif_flit_pkg.sv
lpif_cfg_pkg.sv
lpif_cfg_regs.sv
lpif_auto_sync.sv
lpif_flit_pack.sv
lpif_phy_concat.sv
lpif_link_top.sv
lpif_link_properties.sv
tb_lpif_link.sv
